/* logic/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // Datapath widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Word addresses into the two memories
    typedef logic [9:0]  imem_addr_t;
    typedef logic [9:0]  dmem_addr_t;

    // First instruction fetched after reset or load
    localparam word_t RESET_PC = 32'h0000_0000;

    // Only CSR the core knows about
    localparam logic [11:0] TOHOST_CSR = 12'h51E;

    // addi x0, x0, 0
    localparam word_t NOP = 32'h0000_0013;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        // LUI passes the U immediate straight through
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_fmt_t;

    typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE, BR_LT} br_kind_t;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_src_t;

    // Controls consumed in execute
    typedef struct packed {
        alu_op_t  alu_op;
        logic     a_pc;
        logic     b_imm;
        br_kind_t br;
        logic     jump;
        logic     mem_we;
        logic     csr_we;
    } ex_ctrl_t;

    // Controls consumed in memory/writeback
    typedef struct packed {
        logic      reg_we;
        reg_addr_t rd;
        wb_src_t   src;
    } wb_ctrl_t;

endpackage

`default_nettype wire

/* logic/imm_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module imm_gen (
    input  cpu_pkg::word_t inst,
    output cpu_pkg::word_t imm
);
    import cpu_pkg::*;

    imm_fmt_t fmt;

    // Format follows the opcode alone
    always_comb begin
        case (inst[6:0])
            OPC_STORE:  fmt = IMM_S;
            OPC_BRANCH: fmt = IMM_B;
            OPC_LUI:    fmt = IMM_U;
            OPC_JAL:    fmt = IMM_J;
            // OP-IMM, loads, CSR address
            default:    fmt = IMM_I;
        endcase
    end

    // Bit 31 is the sign in every format
    always_comb begin
        case (fmt)
            IMM_S: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            // Branch offsets are in half words
            IMM_B: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            // Upper 20 bits, low 12 cleared
            IMM_U: imm = {inst[31:12], 12'b0};
            IMM_J: imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = {{20{inst[31]}}, inst[31:20]};
        endcase
    end

endmodule

`default_nettype wire

/* logic/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  cpu_pkg::word_t  a,
    input  cpu_pkg::word_t  b,
    input  cpu_pkg::alu_op_t op,
    output cpu_pkg::word_t  result,
    output logic            br_eq,
    output logic            br_lt
);
    import cpu_pkg::*;

    logic signed_lt;

    // Shared by SLT and the branch flag
    assign signed_lt = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            // Zero-extended compare bit
            ALU_SLT:    result = {31'b0, signed_lt};
            // Shift amount is the low five bits only
            ALU_SLL:    result = a << b[4:0];
            ALU_SRL:    result = a >> b[4:0];
            ALU_PASS_B: result = b;
            default:    result = a + b;
        endcase
    end

    // Branch flags on the operands as muxed in
    assign br_eq = (a == b);
    assign br_lt = signed_lt;

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic              clk,
    input  logic              we,
    input  cpu_pkg::reg_addr_t ra1,
    input  cpu_pkg::reg_addr_t ra2,
    input  cpu_pkg::reg_addr_t wa,
    input  cpu_pkg::word_t    wd,
    output cpu_pkg::word_t    rd1,
    output cpu_pkg::word_t    rd2
);
    import cpu_pkg::*;

    word_t regs [32];

    // Writes to x0 are dropped
    always_ff @(posedge clk) begin
        if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    // Asynchronous reads, x0 hardwired
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

/* logic/control_logic.sv */
`timescale 1ns/100ps
`default_nettype none

module control_logic (
    input  cpu_pkg::word_t    inst_x,
    input  cpu_pkg::word_t    inst_mw,
    input  logic              br_eq,
    input  logic              br_lt,
    output cpu_pkg::ex_ctrl_t ex_ctrl,
    output cpu_pkg::wb_ctrl_t wb_ctrl,
    output logic              fwd_a,
    output logic              fwd_b,
    output logic              redirect
);
    import cpu_pkg::*;

    logic [6:0] opc_x;
    logic [2:0] f3_x;
    logic [6:0] opc_mw;
    logic       wb_writes;
    logic       br_taken;

    // funct3 to ALU operation, shared by OP and OP-IMM
    function automatic alu_op_t arith_op(input logic [2:0] funct3, input logic sub);
        case (funct3)
            3'b000:  return sub ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b101:  return ALU_SRL;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    assign opc_x  = inst_x[6:0];
    assign f3_x   = inst_x[14:12];
    assign opc_mw = inst_mw[6:0];

    // Execute stage decode
    always_comb begin
        ex_ctrl = '0;
        case (opc_x)
            OPC_OP_IMM: begin
                ex_ctrl.alu_op = arith_op(f3_x, 1'b0);
                ex_ctrl.b_imm  = 1'b1;
            end
            // Bit 30 picks SUB over ADD
            OPC_OP: ex_ctrl.alu_op = arith_op(f3_x, inst_x[30]);
            OPC_LUI: begin
                ex_ctrl.alu_op = ALU_PASS_B;
                ex_ctrl.b_imm  = 1'b1;
            end
            // Address is rs1 plus offset
            OPC_LOAD: ex_ctrl.b_imm = 1'b1;
            OPC_STORE: begin
                ex_ctrl.b_imm  = 1'b1;
                ex_ctrl.mem_we = 1'b1;
            end
            OPC_BRANCH: begin
                case (f3_x)
                    3'b000:  ex_ctrl.br = BR_EQ;
                    3'b001:  ex_ctrl.br = BR_NE;
                    3'b100:  ex_ctrl.br = BR_LT;
                    default: ex_ctrl.br = BR_NONE;
                endcase
            end
            // ALU forms the jump target from PC and offset
            OPC_JAL: begin
                ex_ctrl.a_pc  = 1'b1;
                ex_ctrl.b_imm = 1'b1;
                ex_ctrl.jump  = 1'b1;
            end
            // CSRRW to tohost only
            OPC_SYSTEM: ex_ctrl.csr_we = (f3_x == 3'b001) && (inst_x[31:20] == TOHOST_CSR);
            default: ex_ctrl = '0;
        endcase
    end

    // Writeback stage decode
    always_comb begin
        wb_writes  = 1'b0;
        wb_ctrl.src = WB_ALU;
        case (opc_mw)
            OPC_OP_IMM, OPC_OP, OPC_LUI: wb_writes = 1'b1;
            OPC_LOAD: begin
                wb_writes   = 1'b1;
                wb_ctrl.src = WB_MEM;
            end
            // Link register gets PC+4
            OPC_JAL: begin
                wb_writes   = 1'b1;
                wb_ctrl.src = WB_PC4;
            end
            default: wb_writes = 1'b0;
        endcase
        wb_ctrl.rd = inst_mw[11:7];
        // Writes to x0 never count, so nops never forward
        wb_ctrl.reg_we = wb_writes && (wb_ctrl.rd != '0);
    end

    // Writeback to execute forwarding
    assign fwd_a = wb_ctrl.reg_we && (wb_ctrl.rd == inst_x[19:15]);
    assign fwd_b = wb_ctrl.reg_we && (wb_ctrl.rd == inst_x[24:20]);

    always_comb begin
        case (ex_ctrl.br)
            BR_EQ:   br_taken = br_eq;
            BR_NE:   br_taken = !br_eq;
            BR_LT:   br_taken = br_lt;
            default: br_taken = 1'b0;
        endcase
    end

    // Picks the target and kills the two younger slots
    assign redirect = ex_ctrl.jump || br_taken;

endmodule

`default_nettype wire

/* logic/inst_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module inst_mem #(
    parameter int IMEM_DEPTH = 1024
) (
    input  logic                clk,
    input  logic                we,
    input  cpu_pkg::imem_addr_t waddr,
    input  cpu_pkg::word_t      wdata,
    input  cpu_pkg::imem_addr_t raddr,
    output cpu_pkg::word_t      rdata
);
    import cpu_pkg::*;

    localparam int AW = $clog2(IMEM_DEPTH);

    word_t mem [IMEM_DEPTH];

    // Load port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr[AW-1:0]] <= wdata;
        end
    end

    // Fetch port, one cycle latency
    always_ff @(posedge clk) begin
        rdata <= mem[raddr[AW-1:0]];
    end

endmodule

`default_nettype wire

/* logic/data_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module data_mem #(
    parameter int DMEM_DEPTH = 1024
) (
    input  logic                clk,
    input  logic                we,
    input  cpu_pkg::dmem_addr_t addr,
    input  cpu_pkg::word_t      wdata,
    output cpu_pkg::word_t      rdata
);
    import cpu_pkg::*;

    localparam int AW = $clog2(DMEM_DEPTH);

    word_t mem [DMEM_DEPTH];

    // Single port, old data on a same-cycle write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr[AW-1:0]] <= wdata;
        end
        rdata <= mem[addr[AW-1:0]];
    end

endmodule

`default_nettype wire

/* logic/cpu.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu #(
    parameter int IMEM_DEPTH = 1024,
    parameter int DMEM_DEPTH = 1024
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                load_en,
    input  cpu_pkg::imem_addr_t load_addr,
    input  cpu_pkg::word_t      load_data,
    output logic                tohost_valid,
    output cpu_pkg::word_t      tohost_data
);
    import cpu_pkg::*;

    // Fetch/decode
    word_t      pc_f;
    word_t      pc_fd;
    logic       fd_valid;
    word_t      imem_rdata;
    word_t      inst_fd;
    word_t      imm_fd;
    reg_addr_t  ra1_fd;
    reg_addr_t  ra2_fd;
    word_t      rd1;
    word_t      rd2;
    word_t      rs1_fd;
    word_t      rs2_fd;

    // Execute
    word_t      pc_x;
    word_t      inst_x;
    word_t      imm_x;
    word_t      rs1_x;
    word_t      rs2_x;
    word_t      rs1_fwd;
    word_t      rs2_fwd;
    word_t      alu_a;
    word_t      alu_b;
    word_t      alu_result;
    logic       br_eq;
    logic       br_lt;
    word_t      br_target;
    word_t      redirect_target;
    ex_ctrl_t   ex_ctrl;
    logic       fwd_a;
    logic       fwd_b;
    logic       redirect;

    // Memory/writeback
    word_t      pc_mw;
    word_t      inst_mw;
    word_t      alu_mw;
    word_t      dmem_rdata;
    word_t      wb_val;
    wb_ctrl_t   wb_ctrl;

    inst_mem #(.IMEM_DEPTH(IMEM_DEPTH)) i_inst_mem (
        .clk   (clk),
        .we    (load_en),
        .waddr (load_addr),
        .wdata (load_data),
        .raddr (pc_f[$bits(imem_addr_t)+1:2]),
        .rdata (imem_rdata)
    );

    // Discarded reads come out as nops
    assign inst_fd = fd_valid ? imem_rdata : NOP;
    assign ra1_fd  = inst_fd[19:15];
    assign ra2_fd  = inst_fd[24:20];

    imm_gen i_imm_gen (
        .inst (inst_fd),
        .imm  (imm_fd)
    );

    reg_file i_reg_file (
        .clk (clk),
        .we  (wb_ctrl.reg_we),
        .ra1 (ra1_fd),
        .ra2 (ra2_fd),
        .wa  (wb_ctrl.rd),
        .wd  (wb_val),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    // Same-cycle write bypass into decode
    assign rs1_fd = (wb_ctrl.reg_we && (wb_ctrl.rd == ra1_fd)) ? wb_val : rd1;
    assign rs2_fd = (wb_ctrl.reg_we && (wb_ctrl.rd == ra2_fd)) ? wb_val : rd2;

    control_logic i_control_logic (
        .inst_x   (inst_x),
        .inst_mw  (inst_mw),
        .br_eq    (br_eq),
        .br_lt    (br_lt),
        .ex_ctrl  (ex_ctrl),
        .wb_ctrl  (wb_ctrl),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b),
        .redirect (redirect)
    );

    // Writeback result forwarded into execute
    assign rs1_fwd = fwd_a ? wb_val : rs1_x;
    assign rs2_fwd = fwd_b ? wb_val : rs2_x;
    assign alu_a   = ex_ctrl.a_pc ? pc_x : rs1_fwd;
    assign alu_b   = ex_ctrl.b_imm ? imm_x : rs2_fwd;

    alu i_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (ex_ctrl.alu_op),
        .result (alu_result),
        .br_eq  (br_eq),
        .br_lt  (br_lt)
    );

    // ALU compares for branches, so their target has its own adder
    assign br_target       = pc_x + imm_x;
    assign redirect_target = ex_ctrl.jump ? alu_result : br_target;

    // Loads and stores address the memory from execute
    data_mem #(.DMEM_DEPTH(DMEM_DEPTH)) i_data_mem (
        .clk   (clk),
        .we    (ex_ctrl.mem_we),
        .addr  (alu_result[$bits(dmem_addr_t)+1:2]),
        .wdata (rs2_fwd),
        .rdata (dmem_rdata)
    );

    always_comb begin
        case (wb_ctrl.src)
            WB_MEM:  wb_val = dmem_rdata;
            WB_PC4:  wb_val = pc_mw + 32'd4;
            default: wb_val = alu_mw;
        endcase
    end

    // PC, instruction slots and tohost strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_f         <= RESET_PC;
            fd_valid     <= 1'b0;
            inst_x       <= NOP;
            inst_mw      <= NOP;
            tohost_valid <= 1'b0;
        end else begin
            // Hold at the reset PC while the program loads
            if (load_en) begin
                pc_f <= RESET_PC;
            end else if (redirect) begin
                pc_f <= redirect_target;
            end else begin
                pc_f <= pc_f + 32'd4;
            end
            // Drop the in-flight read on load or redirect
            fd_valid     <= !load_en && !redirect;
            inst_x       <= redirect ? NOP : inst_fd;
            inst_mw      <= inst_x;
            tohost_valid <= ex_ctrl.csr_we;
        end
    end

    // Payload follows the slots
    always_ff @(posedge clk) begin
        pc_fd  <= pc_f;
        pc_x   <= pc_fd;
        imm_x  <= imm_fd;
        rs1_x  <= rs1_fd;
        rs2_x  <= rs2_fd;
        pc_mw  <= pc_x;
        alu_mw <= alu_result;
        if (ex_ctrl.csr_we) begin
            tohost_data <= rs1_fwd;
        end
    end

endmodule

`default_nettype wire

/* bench/cpu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;
    import cpu_pkg::*;

    localparam int    IMEM_DEPTH = 1024;
    localparam int    DMEM_DEPTH = 1024;
    localparam string STIM_FILE  = "bench/cpu_stimulus.txt";

    logic       clk;
    logic       rst;
    logic       load_en;
    imem_addr_t load_addr;
    word_t      load_data;
    logic       tohost_valid;
    word_t      tohost_data;

    // Program image and expected tohost list
    word_t prog [IMEM_DEPTH];
    word_t expected_q [$];
    int    num_words;
    int    num_expect;

    // Monitor and watchdog state
    logic  quiet;
    int    seen;
    int    cycle_count;
    int    cycle_limit;

    cpu #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) i_cpu (
        .clk          (clk),
        .rst          (rst),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .tohost_valid (tohost_valid),
        .tohost_data  (tohost_data)
    );

    // 8 ns period
    always #4 clk = ~clk;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic check_value(input word_t actual, input word_t expected, input string what);
        // Case inequality so X and Z count as wrong
        if (actual !== expected) begin
            stop_with_failure($sformatf("[ERROR] time %0t: %s: got %h, expected %h",
                $time, what, actual, expected));
        end
    endtask

    // Counts in decimal, words and values in hex, # starts a comment
    task automatic read_stimulus();
        int    fd;
        int    section;
        int    count;
        word_t value;
        string line;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            stop_with_failure({"Could not open the stimulus file ", STIM_FILE});
        end
        section = 0;
        count   = 0;
        while ((section < 4) && ($fgets(line, fd) != 0)) begin
            case (section)
                // Program length
                0: begin
                    if ($sscanf(line, "%d", num_words) == 1) begin
                        if (num_words > IMEM_DEPTH) begin
                            stop_with_failure("The program does not fit the instruction memory");
                        end
                        section = (num_words > 0) ? 1 : 2;
                    end
                end
                // Instruction words in address order
                1: begin
                    if ($sscanf(line, "%h", value) == 1) begin
                        prog[count] = value;
                        count = count + 1;
                        if (count == num_words) begin
                            section = 2;
                        end
                    end
                end
                // Length of the expected list
                2: begin
                    if ($sscanf(line, "%d", num_expect) == 1) begin
                        section = (num_expect > 0) ? 3 : 4;
                    end
                end
                default: begin
                    if ($sscanf(line, "%h", value) == 1) begin
                        expected_q.push_back(value);
                        if (expected_q.size() == num_expect) begin
                            section = 4;
                        end
                    end
                end
            endcase
        end
        $fclose(fd);
        if (section != 4) begin
            stop_with_failure("The stimulus file ended before all words and values were read");
        end
        // Bound grows with the program length
        cycle_limit = 20 * num_words + 100;
    endtask

    // One word per cycle through the load port, starting at the reset release edge
    task automatic load_program();
        for (int i = 0; i < num_words; i++) begin
            load_en   <= 1'b1;
            load_addr <= imem_addr_t'(i);
            load_data <= prog[i];
            @(posedge clk);
        end
        load_en <= 1'b0;
        quiet   <= 1'b0;
    endtask

    // Sampled mid cycle, away from the DUT edge
    always @(negedge clk) begin
        if (quiet) begin
            check_value({31'b0, tohost_valid}, 32'd0, "tohost_valid during reset or loading");
        end else if (tohost_valid) begin
            if (seen >= num_expect) begin
                stop_with_failure("tohost was written more often than the expected list allows");
            end else begin
                check_value(tohost_data, expected_q[seen], $sformatf("tohost value %0d", seen));
                seen = seen + 1;
            end
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if ((cycle_limit > 0) && (cycle_count >= cycle_limit)) begin
            stop_with_failure($sformatf(
                "Timeout: tohost results never arrived, %0d of %0d seen after %0d cycles",
                seen, num_expect, cycle_count));
        end
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        quiet       = 1'b1;
        seen        = 0;
        cycle_count = 0;
        cycle_limit = 0;
        num_words   = 0;
        num_expect  = 0;
        read_stimulus();
        // Reset over 8 clock edges
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        load_program();
        wait (seen == num_expect);
        // Short drain to catch a stray extra write
        repeat (10) @(posedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/cpu_stimulus.txt */
# Decimal word count, then one hex instruction word per line in address order
# Decimal value count, then the expected tohost values in hex in program order
39
00500093  # 00 addi  x1, x0, 5
ffd00113  # 04 addi  x2, x0, -3
002081b3  # 08 add   x3, x1, x2
51e19073  # 0c csrrw x0, tohost, x3
00112233  # 10 slt   x4, x2, x1
51e21073  # 14 csrrw x0, tohost, x4
123452b7  # 18 lui   x5, 0x12345
0012c333  # 1c xor   x6, x5, x1
51e31073  # 20 csrrw x0, tohost, x6
00409393  # 24 slli  x7, x1, 4
00115433  # 28 srl   x8, x2, x1
005474b3  # 2c and   x9, x8, x5
0074e4b3  # 30 or    x9, x9, x7
401484b3  # 34 sub   x9, x9, x1
51e49073  # 38 csrrw x0, tohost, x9
00602423  # 3c sw    x6, 8(x0)
00902623  # 40 sw    x9, 12(x0)
00802503  # 44 lw    x10, 8(x0)
00150513  # 48 addi  x10, x10, 1
51e51073  # 4c csrrw x0, tohost, x10
00c02583  # 50 lw    x11, 12(x0)
51e59073  # 54 csrrw x0, tohost, x11
00308663  # 58 beq   x1, x3, 0x64 not taken
51e09073  # 5c csrrw x0, tohost, x1
00309663  # 60 bne   x1, x3, 0x6c taken
51e11073  # 64 csrrw x0, tohost, x2 killed
06300093  # 68 addi  x1, x0, 99 killed
00114663  # 6c blt   x2, x1, 0x78 taken
51e19073  # 70 csrrw x0, tohost, x3 killed
51e19073  # 74 csrrw x0, tohost, x3 killed
0020c463  # 78 blt   x1, x2, 0x80 not taken
51e09073  # 7c csrrw x0, tohost, x1
00c0066f  # 80 jal   x12, 0x8c
51e11073  # 84 csrrw x0, tohost, x2 killed
00000613  # 88 addi  x12, x0, 0 killed
51e61073  # 8c csrrw x0, tohost, x12
0000006f  # 90 jal   x0, 0x90
00000013  # 94 nop
00000013  # 98 nop
9
00000002  # 5 + -3
00000001  # -3 < 5
12345005  # lui xor 5
0234504b  # srl and or sub chain
12345006  # load then addi
0234504b  # second address
00000005  # after not-taken beq
00000005  # x1 untouched by killed addi
00000084  # jal link

/* flist.f */
logic/cpu_pkg.sv
logic/imm_gen.sv
logic/alu.sv
logic/reg_file.sv
logic/control_logic.sv
logic/inst_mem.sv
logic/data_mem.sv
logic/cpu.sv
bench/cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= cpu_tb
FLIST     ?= flist.f

OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "No pass status in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
